/* build.f */
+incdir+.
uart_hub_pkg.sv
uart_rx.sv
rx_arbiter.sv
rx_fifo.sv
uart_hub_top.sv
uart_hub_asserts.sv
uart_hub_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = uart_hub_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* uart_hub_tb.sv */
// testbench for the two-channel UART receive hub
// plays a frame table on both serial lines against a randomly stalled host,
// then checks a short glitch and a receiver overrun under back-pressure

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module uart_hub_tb
    import uart_hub_pkg::*;
();

    localparam int R     = `UART_HUB_CLK_FREQ / `UART_HUB_BAUD_RATE;
    localparam int NROWS = 10;

    // row layout: channel [17], byte [16:9], stop bit [8], idle clocks before the start bit [7:0]
    localparam logic [17:0] TAB [NROWS] = '{
        {1'b0, 8'h55, 1'b1, 8'd4},
        {1'b1, 8'h96, 1'b1, 8'd4},
        {1'b0, 8'hA3, 1'b1, 8'd6},
        {1'b1, 8'h3C, 1'b1, 8'd4},
        {1'b0, 8'h0F, 1'b0, 8'd5},
        {1'b1, 8'hE1, 1'b0, 8'd9},
        {1'b0, 8'hC8, 1'b1, 8'd4},
        {1'b1, 8'h00, 1'b1, 8'd4},
        {1'b0, 8'h7E, 1'b1, 8'd12},
        {1'b1, 8'hFF, 1'b1, 8'd4}
    };

    logic       clk_i;
    logic       arstn_i;
    logic       line0;
    logic       line1;
    logic       m_ready_i;
    logic       m_valid_o;
    rx_word_t   m_word_o;
    logic [1:0] frame_err_o;
    logic [1:0] ovr_o;
    logic       stall;
    logic [1:0] drv_done;
    logic [7:0] exp_q [2][$];
    int         err_cnt [2];
    int         err_exp [2];
    int         ovr_cnt [2];
    int         mism_errs;
    int         other_errs;
    int         seed;
    int         rnd;

    uart_hub_top DUT (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .rx_i        ({line1, line0}),
        .m_valid_o   (m_valid_o),
        .m_word_o    (m_word_o),
        .m_ready_i   (m_ready_i),
        .frame_err_o (frame_err_o),
        .ovr_o       (ovr_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        rnd = $random(seed);
        m_ready_i <= stall ? 1'b0 : rnd[0];
    end

    // the tag picks the queue, so a wrong tag shows up as a wrong byte
    task automatic check_word(input rx_word_t w);
        logic [7:0] exp;
        if (exp_q[w.chan].size() == 0) begin
            $display("unexpected word %h on channel %0d", w.data, w.chan);
            other_errs++;
        end else begin
            exp = exp_q[w.chan].pop_front();
            if (w.data !== exp) begin
                $display("Mismatch m_word_o.data ch%0d: got %h expected %h", w.chan, w.data, exp);
                mism_errs++;
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (arstn_i) begin
            for (int c = 0; c < 2; c++) begin
                err_cnt[c] += int'(frame_err_o[c]);
                ovr_cnt[c] += int'(ovr_o[c]);
            end
            if (m_valid_o && m_ready_i) begin
                check_word(m_word_o);
            end
        end
    end

    task automatic drive_line(input int ch, input logic v);
        if (ch == 0) begin
            line0 <= v;
        end else begin
            line1 <= v;
        end
    endtask

    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk_i);
            drive_line(ch, bits[b]);
            repeat (R - 1) @(posedge clk_i);
        end
        @(posedge clk_i);
        drive_line(ch, 1'b1);
    endtask

    task automatic play_channel(input int ch);
        for (int i = 0; i < NROWS; i++) begin
            if (int'(TAB[i][17]) == ch) begin
                repeat (TAB[i][7:0]) @(posedge clk_i);
                send_frame(ch, TAB[i][16:9], TAB[i][8]);
            end
        end
        drv_done[ch] = 1'b1;
    endtask

    // 0 both line drivers done, 1 every expected word seen, 2 an overrun pulse seen
    function automatic logic reached(input int what);
        case (what)
            0: return drv_done == 2'b11;
            1: return exp_q[0].size() == 0 && exp_q[1].size() == 0;
            default: return ovr_cnt[0] != 0;
        endcase
    endfunction

    task automatic wait_for(input int what, input int limit);
        int n;
        n = 0;
        while (!reached(what) && n < limit) begin
            @(posedge clk_i);
            n++;
        end
        if (!reached(what)) begin
            $display("timeout after %0d clocks waiting on condition %0d", limit, what);
            other_errs++;
        end
    endtask

    initial begin
        clk_i     = 1'b0;
        arstn_i   = 1'b0;
        line0     = 1'b1;
        line1     = 1'b1;
        m_ready_i = 1'b0;
        stall     = 1'b0;
        drv_done  = 2'b00;
        seed      = 17098;
        for (int i = 0; i < NROWS; i++) begin
            if (TAB[i][8]) begin
                exp_q[TAB[i][17]].push_back(TAB[i][16:9]);
            end else begin
                err_exp[TAB[i][17]]++;
            end
        end
        repeat (3) @(posedge clk_i);
        arstn_i <= 1'b1;
        fork
            play_channel(0);
            play_channel(1);
        join_none
        wait_for(0, 4000);
        wait_for(1, 500);

        // a quarter-bit low pulse is rejected at the start midpoint
        @(posedge clk_i);
        line0 <= 1'b0;
        repeat (R / 4) @(posedge clk_i);
        line0 <= 1'b1;
        repeat (3 * R) @(posedge clk_i);

        // four words fill the FIFO, the fifth stays in the receiver, the last is lost
        stall <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            exp_q[0].push_back(8'h10 + 8'(i));
            send_frame(0, 8'h10 + 8'(i), 1'b1);
            repeat (4) @(posedge clk_i);
        end
        send_frame(0, 8'hFF, 1'b1);
        wait_for(2, 4 * R);
        stall <= 1'b0;
        wait_for(1, 500);
        repeat (2 * R) @(posedge clk_i);

        for (int c = 0; c < 2; c++) begin
            if (err_cnt[c] != err_exp[c]) begin
                $display("Mismatch frame_err_o[%0d] pulses: got %h expected %h",
                         c, err_cnt[c], err_exp[c]);
                mism_errs++;
            end
            if (ovr_cnt[c] != ((c == 0) ? 1 : 0)) begin
                $display("Mismatch ovr_o[%0d] pulses: got %h expected %h",
                         c, ovr_cnt[c], (c == 0) ? 1 : 0);
                mism_errs++;
            end
        end
        $display("%0d mismatches, %0d other errors", mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* uart_hub_asserts.sv */
// stream and frame error checks for the UART receive hub
// bound into the top level next to the receivers, arbiter and FIFO

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module uart_hub_asserts
    import uart_hub_pkg::*;
(
    input logic                          clk_i,
    input logic                          arstn_i,
    input logic                          m_valid_i,
    input rx_word_t                      m_word_i,
    input logic                          m_ready_i,
    input logic [`UART_HUB_NUM_CHAN-1:0] frame_err_i
);

    // a word offered to a stalled host stays put until it is taken
    stream_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_word_i))
        else $error("output word changed or vanished while the host stalled");

    reset_quiet: assert property (@(posedge clk_i) !arstn_i |-> !m_valid_i)
        else $error("m_valid_o high during reset");

    err_pulse: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (frame_err_i & $past(frame_err_i)) == '0)
        else $error("frame_err_o held for two cycles");

endmodule

bind uart_hub_top uart_hub_asserts u_asserts (
    .clk_i       (clk_i),
    .arstn_i     (arstn_i),
    .m_valid_i   (m_valid_o),
    .m_word_i    (m_word_o),
    .m_ready_i   (m_ready_i),
    .frame_err_i (frame_err_o)
);

/* uart_hub_top.sv */
// two-channel UART receive hub
// one serial receiver per line, a round-robin arbiter into a shared
// FIFO, and a tagged valid/ready stream out to the host

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module uart_hub_top
    import uart_hub_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          arstn_i,
    input  logic [`UART_HUB_NUM_CHAN-1:0] rx_i,
    output logic                          m_valid_o,
    output rx_word_t                      m_word_o,
    input  logic                          m_ready_i,
    output logic [`UART_HUB_NUM_CHAN-1:0] frame_err_o,
    output logic [`UART_HUB_NUM_CHAN-1:0] ovr_o
);

    localparam int NC = `UART_HUB_NUM_CHAN;
    localparam int DW = `UART_HUB_DATA_WIDTH;

    logic [NC-1:0]         rx_valid;
    logic [NC-1:0][DW-1:0] rx_data;
    logic [NC-1:0]         rx_ready;
    logic                  wr_valid;
    rx_word_t              wr_word;
    logic                  wr_ready;

    for (genvar i = 0; i < NC; i++) begin : gen_rx
        uart_rx u_rx (
            .clk_i       (clk_i),
            .arstn_i     (arstn_i),
            .rx_i        (rx_i[i]),
            .rx_valid_o  (rx_valid[i]),
            .rx_data_o   (rx_data[i]),
            .rx_ready_i  (rx_ready[i]),
            .frame_err_o (frame_err_o[i]),
            .ovr_o       (ovr_o[i])
        );
    end

    rx_arbiter u_arb (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .req_valid_i (rx_valid),
        .req_data_i  (rx_data),
        .req_ready_o (rx_ready),
        .wr_valid_o  (wr_valid),
        .wr_word_o   (wr_word),
        .wr_ready_i  (wr_ready)
    );

    rx_fifo u_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .wr_valid_i (wr_valid),
        .wr_word_i  (wr_word),
        .wr_ready_o (wr_ready),
        .m_valid_o  (m_valid_o),
        .m_word_o   (m_word_o),
        .m_ready_i  (m_ready_i)
    );

endmodule

/* rx_fifo.sv */
// shared receive FIFO of tagged bytes
// circular buffer with pointers one bit wider than the address,
// written by the arbiter and read by the host over valid/ready;
// a write and a read may happen in the same cycle

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module rx_fifo
    import uart_hub_pkg::*;
#(
    parameter int DEPTH = `UART_HUB_FIFO_DEPTH
) (
    input  logic     clk_i,
    input  logic     arstn_i,
    input  logic     wr_valid_i,
    input  rx_word_t wr_word_i,
    output logic     wr_ready_o,
    output logic     m_valid_o,
    output rx_word_t m_word_o,
    input  logic     m_ready_i
);

    localparam int AW = $clog2(DEPTH);

    rx_word_t      mem [DEPTH];
    logic [AW:0]   wr_ptr_q;
    logic [AW:0]   rd_ptr_q;
    logic          full;
    logic          empty;
    logic          do_wr;
    logic          do_rd;

    // same address with opposite wrap bits means every slot is taken
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign wr_ready_o = ~full;
    assign m_valid_o  = ~empty;
    assign m_word_o   = mem[rd_ptr_q[AW-1:0]];

    assign do_wr = wr_valid_i & wr_ready_o;
    assign do_rd = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q[AW-1:0]] <= wr_word_i;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr_q <= '0;
        end else if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_ptr_q <= '0;
        end else if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

endmodule

/* rx_arbiter.sv */
// round-robin arbiter for the receive channels
// grants one valid receiver per cycle write access to the shared FIFO
// and tags the granted byte with its channel index

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module rx_arbiter
    import uart_hub_pkg::*;
(
    input  logic                                                    clk_i,
    input  logic                                                    arstn_i,
    input  logic [`UART_HUB_NUM_CHAN-1:0]                           req_valid_i,
    input  logic [`UART_HUB_NUM_CHAN-1:0][`UART_HUB_DATA_WIDTH-1:0] req_data_i,
    output logic [`UART_HUB_NUM_CHAN-1:0]                           req_ready_o,
    output logic                                                    wr_valid_o,
    output rx_word_t                                                wr_word_o,
    input  logic                                                    wr_ready_i
);

    localparam int NC = `UART_HUB_NUM_CHAN;

    chan_t prio_q;
    chan_t grant;
    logic  xfer;

    // scan from the lowest priority up so the last hit is the winner
    always_comb begin
        int cand;
        grant      = prio_q;
        wr_valid_o = 1'b0;
        for (int i = NC - 1; i >= 0; i--) begin
            cand = (int'(prio_q) + i) % NC;
            if (req_valid_i[cand]) begin
                grant      = chan_t'(cand);
                wr_valid_o = 1'b1;
            end
        end
    end

    assign xfer = wr_valid_o & wr_ready_i;

    always_comb begin
        req_ready_o        = '0;
        req_ready_o[grant] = wr_ready_i & wr_valid_o;
    end

    assign wr_word_o.chan = grant;
    assign wr_word_o.data = req_data_i[grant];

    // on a stall the pointer parks on the winner so the offered word stays put
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            prio_q <= '0;
        end else if (wr_valid_o) begin
            prio_q <= xfer ? chan_t'((int'(grant) + 1) % NC) : grant;
        end
    end

endmodule

/* uart_rx.sv */
// UART serial receiver, 8N1
// oversamples the line with a baud counter, checks start and stop bits
// and holds each good byte in its output register until the valid/ready
// transfer; pulses frame_err_o on a low stop bit and ovr_o when a new
// start edge arrives while a byte is still held

`timescale 1ns/1ps
`include "uart_hub_config.svh"

module uart_rx
    import uart_hub_pkg::*;
#(
    parameter int CLK_FREQ  = `UART_HUB_CLK_FREQ,
    parameter int BAUD_RATE = `UART_HUB_BAUD_RATE
) (
    input  logic                            clk_i,
    input  logic                            arstn_i,
    input  logic                            rx_i,
    output logic                            rx_valid_o,
    output logic [`UART_HUB_DATA_WIDTH-1:0] rx_data_o,
    input  logic                            rx_ready_i,
    output logic                            frame_err_o,
    output logic                            ovr_o
);

    localparam int RATIO = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W = $clog2(RATIO);
    localparam int DW    = `UART_HUB_DATA_WIDTH;
    localparam int BIT_W = $clog2(DW);

    rx_state_e        state_q;
    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             rx_prev_q;
    logic [CNT_W-1:0] baud_cnt_q;
    logic [BIT_W-1:0] bit_cnt_q;
    logic [DW-1:0]    shift_q;
    logic             fall;
    logic             baud_done;
    logic             take;

    // the idle line is high, so the synchronizer resets to one
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign fall       = rx_prev_q & ~rx_sync_q;
    assign rx_valid_o = (state_q == RX_HOLD);
    assign take       = rx_valid_o & rx_ready_i;

    // half a bit in start lands every later sample on a bit midpoint
    assign baud_done = (state_q == RX_START) ? (baud_cnt_q == CNT_W'(RATIO / 2 - 1))
                                             : (baud_cnt_q == CNT_W'(RATIO - 1));

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt_q <= '0;
        end else if (baud_done || state_q == RX_IDLE || state_q == RX_HOLD) begin
            baud_cnt_q <= '0;
        end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q     <= RX_IDLE;
            bit_cnt_q   <= '0;
            frame_err_o <= 1'b0;
            ovr_o       <= 1'b0;
        end else begin
            frame_err_o <= 1'b0;
            ovr_o       <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    bit_cnt_q <= '0;
                    if (baud_done) begin
                        state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (baud_done) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_W'(DW - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (baud_done) begin
                        state_q     <= rx_sync_q ? RX_HOLD : RX_IDLE;
                        frame_err_o <= ~rx_sync_q;
                    end
                end
                RX_HOLD: begin
                    // a start edge on the transfer cycle is still caught
                    if (take) begin
                        state_q <= fall ? RX_START : RX_IDLE;
                    end else if (fall) begin
                        ovr_o <= 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first and shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && baud_done) begin
            shift_q <= {rx_sync_q, shift_q[DW-1:1]};
        end
        if (state_q == RX_STOP && baud_done && rx_sync_q) begin
            rx_data_o <= shift_q;
        end
    end

endmodule

/* uart_hub_pkg.sv */
// UART receive hub types
// receiver FSM states, channel index and the tagged word that
// travels from the arbiter through the FIFO to the host

`include "uart_hub_config.svh"

package uart_hub_pkg;

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,
        RX_START = 3'd1,
        RX_DATA  = 3'd2,
        RX_STOP  = 3'd3,
        RX_HOLD  = 3'd4
    } rx_state_e;

    typedef logic [$clog2(`UART_HUB_NUM_CHAN)-1:0] chan_t;

    // channel tag sits above the data byte
    typedef struct packed {
        chan_t                           chan;
        logic [`UART_HUB_DATA_WIDTH-1:0] data;
    } rx_word_t;

endpackage

/* uart_hub_config.svh */
// UART receive hub configuration
// clock, line rate, frame width, channel count and FIFO depth
// shared by the package and every RTL block of the hub

`ifndef UART_HUB_CONFIG_SVH
`define UART_HUB_CONFIG_SVH

// system clock in Hz
`define UART_HUB_CLK_FREQ 1_600_000

// serial line rate, 16 clocks per bit at the default clock
`define UART_HUB_BAUD_RATE 100_000

// data bits per 8N1 frame
`define UART_HUB_DATA_WIDTH 8

// number of serial receivers sharing the FIFO
`define UART_HUB_NUM_CHAN 2

// FIFO entries, must be a power of two
`define UART_HUB_FIFO_DEPTH 4

`endif
